/* logic/fb_soak_pkg.sv */
// frame buffer soak tester, shared definitions
// frame geometry, store depth, word layout and blanking defaults
// scaled down geometry so a soak run simulates quickly
package fb_soak_pkg;

	// ------------------------------------------------------------
	// frame geometry
	// ------------------------------------------------------------
	localparam logic [15:0] LINE_ACTIVE_PIX_NUM   = 16'd8;
	localparam int          LINE_ACTIVE_NUMBER    = 4;
	localparam int          FRAME_SIZE            = 32;
	localparam int          FRAME_DEPTH           = 4;
	localparam int          FRAME_TO_LINE_PIX_NUM = 3;

	// blanking used when nothing else is asked for
	localparam int          DEF_LINE_HIDE         = 4;
	localparam int          DEF_FRAME_HIDE        = 20;

	// ------------------------------------------------------------
	// word layout
	// ------------------------------------------------------------
	// pixel word: frame index in [31:16], pixel index in [15:0]
	localparam int          PIX_W                 = 32;
	// read word: pixel word plus last-word flag in bit 32
	localparam int          BUF_W                 = 33;
	// store address = {slot, word}
	localparam int          SLOT_ADDR_W           = 2;
	localparam int          WORD_ADDR_W           = 5;

	// timing generator phases
	localparam logic [1:0]  PH_FRAME_HIDE         = 2'd0;
	localparam logic [1:0]  PH_FRAME_TO_LINE      = 2'd1;
	localparam logic [1:0]  PH_LINE_ACTIVE        = 2'd2;
	localparam logic [1:0]  PH_LINE_HIDE          = 2'd3;

endpackage

/* logic/pix_if.sv */
`timescale 1ns/1ps
// pixel write stream between the traffic source and the frame store
// fval and dval qualify data, full flags a refused frame
interface pix_if
	import fb_soak_pkg::*;
();
	// frame and line valid, aligned with data
	logic             fval;
	logic             dval;
	// tagged pixel word
	logic [PIX_W-1:0] data;
	// high for the whole of a dropped frame
	logic             full;

	// traffic generator side
	modport src (
		output fval,
		output dval,
		output data,
		input  full
	);

	// frame store side
	modport sink (
		input  fval,
		input  dval,
		input  data,
		output full
	);
endinterface

/* logic/pattern_timing.sv */
`timescale 1ns/1ps
// frame and line valid strobe generator
// frame hide, frame-to-line gap, then active and hidden line periods
// blanking lengths are latched once per frame period
// a blanking value of zero behaves as one cycle
module pattern_timing
	import fb_soak_pkg::*;
(
	input  logic        w_clk_pix,
	input  logic        i_reset,
	input  logic [15:0] i_line_hide_pix_num,
	input  logic [15:0] i_frame_hide_pix_num,
	output logic        o_fval,
	output logic        o_dval
);
	logic [1:0]  phase;
	logic [15:0] pix_cnt;
	logic [7:0]  line_cnt;
	// blanking held for the whole frame
	logic [15:0] line_hide;
	logic [15:0] frame_hide;
	logic        cnt_last;

	// ------------------------------------------------------------
	// end of the current phase
	// ------------------------------------------------------------
	always_comb begin
		case (phase)
			PH_FRAME_HIDE:    cnt_last = (pix_cnt + 16'd1 >= frame_hide);
			PH_FRAME_TO_LINE: cnt_last = (pix_cnt == 16'(FRAME_TO_LINE_PIX_NUM - 1));
			PH_LINE_ACTIVE:   cnt_last = (pix_cnt == LINE_ACTIVE_PIX_NUM - 16'd1);
			default:          cnt_last = (pix_cnt + 16'd1 >= line_hide);
		endcase
	end

	// ------------------------------------------------------------
	// phase sequencer
	// ------------------------------------------------------------
	always_ff @(posedge w_clk_pix) begin
		if (i_reset) begin
			phase      <= PH_FRAME_HIDE;
			pix_cnt    <= '0;
			line_cnt   <= '0;
			line_hide  <= i_line_hide_pix_num;
			frame_hide <= i_frame_hide_pix_num;
		end else if (cnt_last) begin
			pix_cnt <= '0;
			case (phase)
				PH_FRAME_HIDE:    phase <= PH_FRAME_TO_LINE;
				PH_FRAME_TO_LINE: phase <= PH_LINE_ACTIVE;
				PH_LINE_ACTIVE:   phase <= PH_LINE_HIDE;
				PH_LINE_HIDE: begin
					if (line_cnt == 8'(LINE_ACTIVE_NUMBER - 1)) begin
						// last line done, fval drops next cycle
						phase      <= PH_FRAME_HIDE;
						line_cnt   <= '0;
						line_hide  <= i_line_hide_pix_num;
						frame_hide <= i_frame_hide_pix_num;
					end else begin
						phase    <= PH_LINE_ACTIVE;
						line_cnt <= line_cnt + 8'd1;
					end
				end
				default: phase <= PH_FRAME_HIDE;
			endcase
		end else begin
			pix_cnt <= pix_cnt + 16'd1;
		end
	end

	// strobes straight from the phase
	assign o_fval = (phase != PH_FRAME_HIDE);
	assign o_dval = (phase == PH_LINE_ACTIVE);

	// first line starts a fixed gap after the frame start
	a_frame_to_line: assert property (@(posedge w_clk_pix) disable iff (i_reset)
		$rose(o_dval) && (line_cnt == '0) |->
			$past(o_fval, FRAME_TO_LINE_PIX_NUM) && !$past(o_fval, FRAME_TO_LINE_PIX_NUM + 1));
endmodule

/* logic/traffic_gen_check.sv */
`timescale 1ns/1ps
// traffic source and sequence checker around the frame store
// write side tags each pixel with frame and pixel index
// read side drains the store and grades every frame good or bad
module traffic_gen_check
	import fb_soak_pkg::*;
(
	input  logic             w_clk_pix,
	input  logic             i_reset,
	input  logic             i_fval,
	input  logic             i_dval,
	pix_if.src               o_wr,
	input  logic             i_rd_pause,
	input  logic             i_buf_empty,
	output logic             o_buf_rd,
	input  logic [BUF_W-1:0] i_buf_dout,
	output logic             o_good_frame,
	output logic             o_bad_frame
);
	logic        fval_d;
	logic [15:0] tx_frame;
	logic [15:0] tx_pix;
	logic        rd_vld;
	logic [15:0] rx_pix;
	logic [15:0] rx_frame;
	logic [15:0] last_frame;
	logic        have_last;
	logic        frame_err;
	logic        word_flag;
	logic [15:0] word_frame;
	logic [15:0] word_pix;
	logic [15:0] exp_frame;
	logic        word_bad;

	// ------------------------------------------------------------
	// write side
	// ------------------------------------------------------------
	always_ff @(posedge w_clk_pix) begin
		if (i_reset) begin
			fval_d   <= 1'b0;
			tx_frame <= '0;
			tx_pix   <= '0;
		end else begin
			fval_d <= i_fval;
			if (fval_d && !i_fval) begin
				// frame sent, dropped or not
				tx_frame <= tx_frame + 16'd1;
				tx_pix   <= '0;
			end else if (i_fval && i_dval) begin
				tx_pix <= tx_pix + 16'd1;
			end
		end
	end

	assign o_wr.fval = i_fval;
	assign o_wr.dval = i_dval;
	assign o_wr.data = {tx_frame, tx_pix};

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	// drain whenever something is there
	assign o_buf_rd   = !i_buf_empty && !i_rd_pause;
	assign word_flag  = i_buf_dout[BUF_W-1];
	assign word_frame = i_buf_dout[PIX_W-1:16];
	assign word_pix   = i_buf_dout[15:0];

	always_comb begin
		// first word opens a new frame index, the rest repeat it
		exp_frame = (rx_pix == '0) ? last_frame + 16'd1 : rx_frame;
		word_bad  = (word_pix != rx_pix);
		word_bad  = word_bad || (word_flag != (rx_pix == 16'(FRAME_SIZE - 1)));
		// first frame after reset taken as it comes
		if (rx_pix != '0 || have_last) begin
			word_bad = word_bad || (word_frame != exp_frame);
		end
	end

	always_ff @(posedge w_clk_pix) begin
		if (i_reset) begin
			rd_vld       <= 1'b0;
			rx_pix       <= '0;
			rx_frame     <= '0;
			last_frame   <= '0;
			have_last    <= 1'b0;
			frame_err    <= 1'b0;
			o_good_frame <= 1'b0;
			o_bad_frame  <= 1'b0;
		end else begin
			rd_vld       <= o_buf_rd;
			o_good_frame <= 1'b0;
			o_bad_frame  <= 1'b0;
			if (rd_vld) begin
				if (word_flag) begin
					// verdict on the flagged word
					o_good_frame <= !(frame_err || word_bad);
					o_bad_frame  <= frame_err || word_bad;
					last_frame   <= word_frame;
					have_last    <= 1'b1;
					rx_pix       <= '0;
					frame_err    <= 1'b0;
				end else begin
					if (rx_pix == '0) begin
						rx_frame <= word_frame;
					end
					rx_pix    <= rx_pix + 16'd1;
					frame_err <= frame_err || word_bad;
				end
			end
		end
	end

	// store refuses a frame only at its start
	a_full_at_frame_start: assert property (@(posedge w_clk_pix) disable iff (i_reset)
		$rose(o_wr.full) |-> $rose(i_fval));
endmodule

/* logic/frame_store.sv */
`timescale 1ns/1ps
// four-slot whole-frame store
// a frame is taken at fval rise only if a slot is free, else dropped whole
// complete frames are read back in order, word 31 carries the last flag
module frame_store
	import fb_soak_pkg::*;
(
	input  logic             w_clk_pix,
	input  logic             i_reset,
	pix_if.sink              i_wr,
	input  logic             i_buf_rd,
	output logic             o_buf_empty,
	output logic [BUF_W-1:0] o_buf_dout,
	output logic             o_frame_drop
);
	logic [PIX_W-1:0]       mem [0:(1 << (SLOT_ADDR_W + WORD_ADDR_W)) - 1];
	logic                   fval_d;
	logic                   fval_rise;
	logic                   slot_free;
	logic                   drop_q;
	logic                   full_c;
	logic                   wr_en;
	logic                   wr_last;
	logic                   rd_last;
	logic                   wr_frame_done;
	logic [SLOT_ADDR_W-1:0] wr_slot;
	logic [SLOT_ADDR_W-1:0] rd_slot;
	logic [WORD_ADDR_W-1:0] wr_word;
	logic [WORD_ADDR_W-1:0] rd_word;
	// complete frames not yet fully read
	logic [SLOT_ADDR_W:0]   frame_cnt;
	logic [PIX_W-1:0]       rd_data;
	logic                   rd_flag;

	// ------------------------------------------------------------
	// accept or drop at frame start
	// ------------------------------------------------------------
	assign fval_rise    = i_wr.fval && !fval_d;
	assign slot_free    = int'(frame_cnt) < FRAME_DEPTH;
	assign full_c       = i_wr.fval && (fval_rise ? !slot_free : drop_q);
	assign i_wr.full    = full_c;
	assign o_frame_drop = fval_rise && !slot_free;

	assign wr_en   = i_wr.fval && i_wr.dval && !full_c;
	assign wr_last = wr_en && (wr_word == WORD_ADDR_W'(FRAME_SIZE - 1));
	assign rd_last = i_buf_rd && (rd_word == WORD_ADDR_W'(FRAME_SIZE - 1));

	assign o_buf_empty = (frame_cnt == '0);

	// ------------------------------------------------------------
	// pointers and frame count
	// ------------------------------------------------------------
	always_ff @(posedge w_clk_pix) begin
		if (i_reset) begin
			fval_d        <= 1'b0;
			drop_q        <= 1'b0;
			wr_frame_done <= 1'b0;
			wr_slot       <= '0;
			wr_word       <= '0;
			rd_slot       <= '0;
			rd_word       <= '0;
			frame_cnt     <= '0;
		end else begin
			fval_d <= i_wr.fval;
			// drop decision held until fval falls
			if (fval_rise) begin
				drop_q <= !slot_free;
			end else if (!i_wr.fval) begin
				drop_q <= 1'b0;
			end
			if (fval_rise) begin
				wr_frame_done <= 1'b0;
			end else if (wr_last) begin
				wr_frame_done <= 1'b1;
			end
			// word pointer wraps into the next slot
			if (wr_en) begin
				wr_word <= wr_word + 1'b1;
				if (wr_last) begin
					wr_slot <= wr_slot + 1'b1;
				end
			end
			if (i_buf_rd) begin
				rd_word <= rd_word + 1'b1;
				if (rd_last) begin
					rd_slot <= rd_slot + 1'b1;
				end
			end
			// frame readable the cycle after its last word
			case ({wr_last, rd_last})
				2'b10:   frame_cnt <= frame_cnt + 1'b1;
				2'b01:   frame_cnt <= frame_cnt - 1'b1;
				default: frame_cnt <= frame_cnt;
			endcase
		end
	end

	// ------------------------------------------------------------
	// frame RAM
	// ------------------------------------------------------------
	always_ff @(posedge w_clk_pix) begin
		if (wr_en) begin
			mem[{wr_slot, wr_word}] <= i_wr.data;
		end
		if (i_buf_rd) begin
			rd_data <= mem[{rd_slot, rd_word}];
			rd_flag <= (rd_word == WORD_ADDR_W'(FRAME_SIZE - 1));
		end
	end

	assign o_buf_dout = {rd_flag, rd_data};

	// reader must respect empty
	a_no_rd_empty: assert property (@(posedge w_clk_pix) disable iff (i_reset)
		i_buf_rd |-> !o_buf_empty);
	// source frames are exactly one slot long
	a_no_wr_overrun: assert property (@(posedge w_clk_pix) disable iff (i_reset)
		wr_en |-> !wr_frame_done);
endmodule

/* logic/test_ctrl.sv */
`timescale 1ns/1ps
// soak test control
// synchronizes switch and clear, holds the pattern between frames,
// counts sent, good and bad frames, latches overflow, compares counts
module test_ctrl (
	input  logic        w_clk_pix,
	input  logic        i_reset,
	input  logic        i_test_switch,
	input  logic        i_test_clear,
	input  logic        i_fval,
	input  logic        i_dval,
	input  logic        i_full,
	input  logic        i_good_frame,
	input  logic        i_bad_frame,
	output logic        o_reset_pattern,
	output logic [31:0] o_send_frame_cnt,
	output logic [31:0] o_good_frame_cnt,
	output logic [7:0]  o_bad_frame_cnt,
	output logic        o_comp_ok,
	output logic        o_front_fifo_overflow
);
	// bit 1 switch, bit 0 clear
	logic [1:0] ctl_d0;
	logic [1:0] ctl_d1;
	logic       switch_s;
	logic       clear_s;
	logic       fval_d;

	// ------------------------------------------------------------
	// two-flop synchronizers
	// ------------------------------------------------------------
	always_ff @(posedge w_clk_pix) begin
		if (i_reset) begin
			ctl_d0 <= '0;
			ctl_d1 <= '0;
		end else begin
			ctl_d0 <= {i_test_switch, i_test_clear};
			ctl_d1 <= ctl_d0;
		end
	end

	assign switch_s = ctl_d1[1];
	assign clear_s  = ctl_d1[0];

	// pattern held only between frames, running frame finishes
	assign o_reset_pattern = i_reset || (!switch_s && !i_fval);

	// ------------------------------------------------------------
	// counters, overflow latch, compare
	// ------------------------------------------------------------
	always_ff @(posedge w_clk_pix) begin
		if (i_reset || clear_s) begin
			fval_d                <= 1'b0;
			o_send_frame_cnt      <= '0;
			o_good_frame_cnt      <= '0;
			o_bad_frame_cnt       <= '0;
			o_front_fifo_overflow <= 1'b0;
		end else begin
			fval_d <= i_fval;
			// sent frame on fval rise
			if (i_fval && !fval_d) begin
				o_send_frame_cnt <= o_send_frame_cnt + 32'd1;
			end
			if (i_good_frame) begin
				o_good_frame_cnt <= o_good_frame_cnt + 32'd1;
			end
			if (i_bad_frame) begin
				o_bad_frame_cnt <= o_bad_frame_cnt + 8'd1;
			end
			// pixels arriving into a refused frame
			if (i_full && i_dval) begin
				o_front_fifo_overflow <= 1'b1;
			end
		end
	end

	// meaningful only once the test is stopped
	always_ff @(posedge w_clk_pix) begin
		if (i_reset) begin
			o_comp_ok <= 1'b0;
		end else begin
			o_comp_ok <= !switch_s && (o_send_frame_cnt == o_good_frame_cnt);
		end
	end

	// one single-cycle verdict per flagged word
	a_verdict_pulse: assert property (@(posedge w_clk_pix) disable iff (i_reset)
		(i_good_frame || i_bad_frame) |=> !(i_good_frame || i_bad_frame));
endmodule

/* logic/fb_soak_top.sv */
`timescale 1ns/1ps
// frame buffer soak tester top level
// pattern timing, traffic source and checker, frame store, test control
module fb_soak_top
	import fb_soak_pkg::*;
(
	input  logic        w_clk_pix,
	input  logic        i_reset,
	input  logic        i_test_switch,
	input  logic        i_test_clear,
	input  logic        i_rd_pause,
	input  logic [15:0] i_line_hide_pix_num,
	input  logic [15:0] i_frame_hide_pix_num,
	output logic        o_fval,
	output logic        o_dval,
	output logic [31:0] o_send_frame_cnt,
	output logic [31:0] o_good_frame_cnt,
	output logic [7:0]  o_bad_frame_cnt,
	output logic        o_comp_ok,
	output logic        o_front_fifo_overflow
);
	logic             w_reset_pattern;
	logic             w_buf_rd;
	logic             w_buf_empty;
	logic [BUF_W-1:0] w_buf_dout;
	logic             w_good_frame;
	logic             w_bad_frame;

	// write stream into the store
	pix_if u_pix ();

	// ------------------------------------------------------------
	// pattern and traffic
	// ------------------------------------------------------------
	pattern_timing u_pattern_timing (
		.w_clk_pix            (w_clk_pix),
		.i_reset              (w_reset_pattern),
		.i_line_hide_pix_num  (i_line_hide_pix_num),
		.i_frame_hide_pix_num (i_frame_hide_pix_num),
		.o_fval               (o_fval),
		.o_dval               (o_dval)
	);

	traffic_gen_check u_traffic_gen_check (
		.w_clk_pix    (w_clk_pix),
		.i_reset      (i_reset),
		.i_fval       (o_fval),
		.i_dval       (o_dval),
		.o_wr         (u_pix.src),
		.i_rd_pause   (i_rd_pause),
		.i_buf_empty  (w_buf_empty),
		.o_buf_rd     (w_buf_rd),
		.i_buf_dout   (w_buf_dout),
		.o_good_frame (w_good_frame),
		.o_bad_frame  (w_bad_frame)
	);

	// drop pulse left open, overflow comes from full
	frame_store u_frame_store (
		.w_clk_pix    (w_clk_pix),
		.i_reset      (i_reset),
		.i_wr         (u_pix.sink),
		.i_buf_rd     (w_buf_rd),
		.o_buf_empty  (w_buf_empty),
		.o_buf_dout   (w_buf_dout),
		.o_frame_drop ()
	);

	// ------------------------------------------------------------
	// control and statistics
	// ------------------------------------------------------------
	test_ctrl u_test_ctrl (
		.w_clk_pix             (w_clk_pix),
		.i_reset               (i_reset),
		.i_test_switch         (i_test_switch),
		.i_test_clear          (i_test_clear),
		.i_fval                (o_fval),
		.i_dval                (o_dval),
		.i_full                (u_pix.full),
		.i_good_frame          (w_good_frame),
		.i_bad_frame           (w_bad_frame),
		.o_reset_pattern       (w_reset_pattern),
		.o_send_frame_cnt      (o_send_frame_cnt),
		.o_good_frame_cnt      (o_good_frame_cnt),
		.o_bad_frame_cnt       (o_bad_frame_cnt),
		.o_comp_ok             (o_comp_ok),
		.o_front_fifo_overflow (o_front_fifo_overflow)
	);
endmodule

/* verification/fb_soak_tb.sv */
`timescale 1ns/1ps
// frame buffer soak tester testbench
// directed tests for idle, streaming, back-pressure, clear and random blanking
// a strobe monitor checks frame shape and frame period at the top-level ports
module fb_soak_tb
	import fb_soak_pkg::*;
();
	localparam int STREAM_FRAMES  = 5;
	localparam int PAUSE_FRAMES   = 7;
	localparam int RESUME_FRAMES  = 2;
	localparam int BLANK_FRAMES   = 4;
	localparam int PIX_PER_LINE   = int'(LINE_ACTIVE_PIX_NUM);
	// default frame period and the longest one the random hides can give
	localparam int DEF_FRAME_LEN  = DEF_FRAME_HIDE + FRAME_TO_LINE_PIX_NUM
		+ LINE_ACTIVE_NUMBER * (PIX_PER_LINE + DEF_LINE_HIDE);
	localparam int MAX_FRAME_LEN  = 35 + FRAME_TO_LINE_PIX_NUM
		+ LINE_ACTIVE_NUMBER * (PIX_PER_LINE + 8);
	localparam int TIMEOUT_CYCLES = ((STREAM_FRAMES + PAUSE_FRAMES + RESUME_FRAMES)
		* DEF_FRAME_LEN + BLANK_FRAMES * MAX_FRAME_LEN) * 2 + 1000;

	logic        w_clk_pix = 1'b0;
	logic        i_reset;
	logic        i_test_switch;
	logic        i_test_clear;
	logic        i_rd_pause;
	logic [15:0] i_line_hide_pix_num;
	logic [15:0] i_frame_hide_pix_num;
	logic        o_fval;
	logic        o_dval;
	logic [31:0] o_send_frame_cnt;
	logic [31:0] o_good_frame_cnt;
	logic [7:0]  o_bad_frame_cnt;
	logic        o_comp_ok;
	logic        o_front_fifo_overflow;

	int          error_cnt   = 0;
	int          cycles      = 0;
	// strobe monitor state
	int          rise_cnt    = 0;
	int          last_rise   = 0;
	int          last_period = 0;
	int          dval_run    = 0;
	int          dval_total  = 0;
	int          dval_groups = 0;
	logic        fval_q      = 1'b0;
	logic        dval_q      = 1'b0;
	integer      seed        = 4863;

	fb_soak_top DUT (.*);

	always #2 w_clk_pix = ~w_clk_pix;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic step();
		@(posedge w_clk_pix);
		#1;
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got == expected) else begin
			error_cnt = error_cnt + 1;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	// returns just after the edge following the target frame start
	task automatic wait_frame_starts(input int target);
		wait (rise_cnt >= target);
		step();
	endtask

	// checker verdicts as the drain done condition
	task automatic wait_verdicts(input int total);
		wait (o_good_frame_cnt + 32'(o_bad_frame_cnt) >= 32'(total));
		repeat (4) step();
	endtask

	// ------------------------------------------------------------
	// strobe monitor, sampled mid cycle
	// ------------------------------------------------------------
	always @(negedge w_clk_pix) begin
		compare_value("dval outside fval", 32'(o_dval && !o_fval), 0);
		if (o_fval && !fval_q) begin
			rise_cnt    = rise_cnt + 1;
			last_period = cycles - last_rise;
			last_rise   = cycles;
			dval_total  = 0;
			dval_groups = 0;
		end
		if (o_dval) begin
			dval_total = dval_total + 1;
			dval_run   = dval_run + 1;
		end else if (dval_q) begin
			compare_value("dval cycles per line", dval_run, PIX_PER_LINE);
			dval_groups = dval_groups + 1;
			dval_run    = 0;
		end
		// frame shape at fval fall
		if (!o_fval && fval_q) begin
			compare_value("dval cycles per frame", dval_total, FRAME_SIZE);
			compare_value("lines per frame", dval_groups, LINE_ACTIVE_NUMBER);
		end
		fval_q = o_fval;
		dval_q = o_dval;
	end

	always @(posedge w_clk_pix) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run not finished after %0d cycles, %0d errors", cycles, error_cnt);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic idle_after_reset();
		repeat (40) begin
			step();
			compare_value("idle fval", 32'(o_fval), 0);
			compare_value("idle dval", 32'(o_dval), 0);
		end
		compare_value("idle frame starts", rise_cnt, 0);
		compare_value("idle sent count", o_send_frame_cnt, 0);
		compare_value("idle good count", o_good_frame_cnt, 0);
		compare_value("idle bad count", 32'(o_bad_frame_cnt), 0);
		compare_value("idle overflow", 32'(o_front_fifo_overflow), 0);
		compare_value("idle comp_ok", 32'(o_comp_ok), 1);
	endtask

	task automatic stream_frames();
		int first;
		first = rise_cnt;
		i_test_switch = 1'b1;
		wait_frame_starts(first + STREAM_FRAMES);
		// frame in flight still runs to its end
		i_test_switch = 1'b0;
		wait_verdicts(STREAM_FRAMES);
		compare_value("stream frame starts", rise_cnt - first, STREAM_FRAMES);
		compare_value("stream fval after stop", 32'(o_fval), 0);
		compare_value("stream sent count", o_send_frame_cnt, STREAM_FRAMES);
		compare_value("stream good count", o_good_frame_cnt, STREAM_FRAMES);
		compare_value("stream bad count", 32'(o_bad_frame_cnt), 0);
		compare_value("stream overflow", 32'(o_front_fifo_overflow), 0);
		compare_value("stream comp_ok", 32'(o_comp_ok), 1);
	endtask

	task automatic pause_reads();
		int first;
		int sent;
		int dropped;
		int good;
		first   = rise_cnt;
		sent    = STREAM_FRAMES + PAUSE_FRAMES + RESUME_FRAMES;
		dropped = PAUSE_FRAMES - FRAME_DEPTH;
		// one more frame lost to the index jump
		good    = sent - dropped - 1;
		i_rd_pause    = 1'b1;
		i_test_switch = 1'b1;
		wait_frame_starts(first + PAUSE_FRAMES);
		// last paused frame already refused at its start
		i_rd_pause = 1'b0;
		wait_frame_starts(first + PAUSE_FRAMES + RESUME_FRAMES);
		i_test_switch = 1'b0;
		wait_verdicts(good + 1);
		compare_value("pause sent count", o_send_frame_cnt, sent);
		compare_value("pause good count", o_good_frame_cnt, good);
		compare_value("pause bad count", 32'(o_bad_frame_cnt), 1);
		compare_value("pause overflow", 32'(o_front_fifo_overflow), 1);
		compare_value("pause comp_ok", 32'(o_comp_ok), 0);
	endtask

	task automatic clear_counts();
		i_test_clear = 1'b1;
		step();
		i_test_clear = 1'b0;
		step();
		// synchronizer still in flight
		compare_value("overflow before clear", 32'(o_front_fifo_overflow), 1);
		step();
		compare_value("cleared sent count", o_send_frame_cnt, 0);
		compare_value("cleared good count", o_good_frame_cnt, 0);
		compare_value("cleared bad count", 32'(o_bad_frame_cnt), 0);
		compare_value("cleared overflow", 32'(o_front_fifo_overflow), 0);
		step();
		compare_value("cleared comp_ok", 32'(o_comp_ok), 1);
	endtask

	task automatic random_blanking();
		int line_hide;
		int frame_hide;
		int frame_len;
		int first;
		line_hide  = 1 + ($random(seed) & 7);
		frame_hide = 4 + ($random(seed) & 31);
		frame_len  = frame_hide + FRAME_TO_LINE_PIX_NUM
			+ LINE_ACTIVE_NUMBER * (PIX_PER_LINE + line_hide);
		$display("blanking run: line hide %0d, frame hide %0d", line_hide, frame_hide);
		// pattern idle in reset, so the new values are latched now
		i_line_hide_pix_num  = 16'(line_hide);
		i_frame_hide_pix_num = 16'(frame_hide);
		first = rise_cnt;
		i_test_switch = 1'b1;
		for (int k = 1; k <= BLANK_FRAMES; k++) begin
			wait_frame_starts(first + k);
			if (k > 1) begin
				compare_value("frame period", last_period, frame_len);
			end
		end
		i_test_switch = 1'b0;
		wait_verdicts(BLANK_FRAMES);
		compare_value("blanking sent count", o_send_frame_cnt, BLANK_FRAMES);
		compare_value("blanking good count", o_good_frame_cnt, BLANK_FRAMES);
		compare_value("blanking bad count", 32'(o_bad_frame_cnt), 0);
		compare_value("blanking comp_ok", 32'(o_comp_ok), 1);
	endtask

	initial begin
		i_reset              = 1'b1;
		i_test_switch        = 1'b0;
		i_test_clear         = 1'b0;
		i_rd_pause           = 1'b0;
		i_line_hide_pix_num  = 16'(DEF_LINE_HIDE);
		i_frame_hide_pix_num = 16'(DEF_FRAME_HIDE);
		repeat (10) @(posedge w_clk_pix);
		#1;
		i_reset = 1'b0;
		idle_after_reset();
		stream_frames();
		pause_reads();
		clear_counts();
		random_blanking();
		$display("Summary: %0d errors, %0d cycles", error_cnt, cycles);
		if (error_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end
endmodule

/* fb_soak.f */
logic/fb_soak_pkg.sv
logic/pix_if.sv
logic/pattern_timing.sv
logic/traffic_gen_check.sv
logic/frame_store.sv
logic/test_ctrl.sv
logic/fb_soak_top.sv
verification/fb_soak_tb.sv

/* Makefile */
# Verilator build and run for the frame buffer soak tester

VERILATOR ?= verilator
TOP       ?= fb_soak_tb
FILELIST  ?= fb_soak.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Simulation PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "pass message found in $(LOG)" || \
		(echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
